// File: mem_system_macros.svh
/*
 * Size and timing constants for the cache and the banked memory
 * Address split is tag 15..11, index 10..3, byte offset 2..0
 */
`ifndef MEM_SYSTEM_MACROS_SVH
`define MEM_SYSTEM_MACROS_SVH

`define ADDR_W     16
`define WORD_W     16
`define TAG_W      5
`define INDEX_W    8
`define OFFSET_W   3

`define LINE_WORDS 4   // Words per line
`define NUM_SETS   256
`define NUM_BANKS  4   // Bank select is addr[2:1]

`define MEM_RD_LAT 2   // Accept to read data
`define BANK_BUSY  4   // Cycles a bank is held after an access

`endif

// File: addr_pkg.sv
/*
 * Address field and data word types
 * shared by the cache ways, the controller and the memory
 */
`include "mem_system_macros.svh"

package addr_pkg;

   typedef logic [`WORD_W-1:0]   word_t;
   typedef logic [`TAG_W-1:0]    tag_t;
   typedef logic [`INDEX_W-1:0]  index_t;
   typedef logic [`OFFSET_W-1:0] offset_t;

   // One cache line, word 0 in the low bits
   typedef word_t [`LINE_WORDS-1:0] line_t;

endpackage

// File: cache_pkg.sv
/*
 * Tag array entry and controller FSM states
 */
package cache_pkg;

   import addr_pkg::*;

   typedef struct packed {
      logic valid;
      logic dirty;
      tag_t tag;
   } tag_entry_t;

   typedef enum logic [2:0] {
      st_idle,
      st_lookup,
      st_writeback,
      st_fill,        // Issuing line reads
      st_fill_wait,   // Reads in flight, none left to issue
      st_finish
   } ctrl_state_t;

endpackage

// File: way_ram.sv
/*
 * Per-set storage array, element type set by parameter
 * Combinational read, write at the clock edge
 */
`timescale 1ns/1ps
`include "mem_system_macros.svh"

module way_ram
   import addr_pkg::*;
#(
   parameter type T     = logic,
   parameter int  depth = `NUM_SETS
) (
   input  logic   clk,
   input  logic   rst_n,
   input  index_t index,
   input  logic   we,
   input  T       wdata,
   output T       rdata
);

   T mem [depth];

   assign rdata = mem[index];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < depth; i++) begin
            mem[i] <= '0;
         end
      end else if (we) begin
         mem[index] <= wdata;
      end
   end

endmodule

// File: cache_way.sv
/*
 * One cache way, tag array plus line data array
 * Tag compare and hit, dirty, valid reporting
 */
`timescale 1ns/1ps
`include "mem_system_macros.svh"

module cache_way
   import addr_pkg::*, cache_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    en,
   input  index_t  index,
   input  offset_t offset,
   input  tag_t    tag_in,
   input  word_t   data_in,
   input  logic    write,
   input  logic    set_dirty,
   input  logic    fill,
   output word_t   data_out,
   output tag_t    tag_out,
   output logic    hit,
   output logic    dirty,
   output logic    valid
);

   tag_entry_t                entry;
   tag_entry_t                entry_new;
   line_t                     line;
   line_t                     line_new;
   logic [`OFFSET_W-2:0]      word_sel;
   logic                      tag_we;
   logic                      data_we;

   assign word_sel = offset[`OFFSET_W-1:1];   // Byte offset to word

   // New tag goes in with the last word of a refill
   assign tag_we  = en & ((write & set_dirty) | (fill & (word_sel == '1)));
   assign data_we = en & (write | fill);

   always_comb begin
      entry_new = entry;
      if (fill) begin
         entry_new = '{valid: 1'b1, dirty: 1'b0, tag: tag_in};
      end else begin
         entry_new.dirty = 1'b1;
      end
      line_new           = line;
      line_new[word_sel] = data_in;
   end

   way_ram #(.T(tag_entry_t), .depth(`NUM_SETS)) i_tag_ram (
      .clk   (clk),
      .rst_n (rst_n),
      .index (index),
      .we    (tag_we),
      .wdata (entry_new),
      .rdata (entry)
   );

   way_ram #(.T(line_t), .depth(`NUM_SETS)) i_data_ram (
      .clk   (clk),
      .rst_n (1'b1),
      .index (index),
      .we    (data_we),
      .wdata (line_new),
      .rdata (line)
   );

   assign valid    = en & entry.valid;
   assign hit      = valid & (entry.tag == tag_in);
   assign dirty    = valid & entry.dirty;
   assign tag_out  = entry.tag;
   assign data_out = line[word_sel];

endmodule

// File: four_bank_mem.sv
/*
 * Word memory in four interleaved banks
 * Per-bank busy counters, fixed-latency read pipeline
 */
`timescale 1ns/1ps
`include "mem_system_macros.svh"

module four_bank_mem
   import addr_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [`ADDR_W-1:0]    addr,
   input  word_t                 data_in,
   input  logic                  rd,
   input  logic                  wr,
   output word_t                 data_out,
   output logic                  stall,
   output logic [`NUM_BANKS-1:0] busy
);

   localparam int BANK_W = $clog2(`NUM_BANKS);
   localparam int CNT_W  = $clog2(`BANK_BUSY + 1);
   localparam int DEPTH  = 2 ** (`ADDR_W - 1);

   word_t              mem [DEPTH];
   word_t              rd_pipe [`MEM_RD_LAT];
   logic [CNT_W-1:0]   busy_cnt [`NUM_BANKS];
   logic [BANK_W-1:0]  bank;
   logic               acc;

   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   assign bank  = addr[BANK_W:1];
   assign stall = (rd | wr) & busy[bank];
   assign acc   = (rd | wr) & ~busy[bank];

   always_comb begin
      for (int b = 0; b < `NUM_BANKS; b++) begin
         busy[b] = |busy_cnt[b];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int b = 0; b < `NUM_BANKS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < `NUM_BANKS; b++) begin
            if (acc && bank == BANK_W'(b)) begin
               busy_cnt[b] <= CNT_W'(`BANK_BUSY);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // Storage and read data path
   always_ff @(posedge clk) begin
      if (acc && wr) begin
         mem[addr[`ADDR_W-1:1]] <= data_in;
      end
      rd_pipe[0] <= mem[addr[`ADDR_W-1:1]];
      for (int i = 1; i < `MEM_RD_LAT; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   assign data_out = rd_pipe[`MEM_RD_LAT-1];

endmodule

// File: cache_ctrl.sv
/*
 * Cache request FSM with lookup, victim choice, write-back and line fill
 * LRU bits, request error check and processor handshake
 */
`timescale 1ns/1ps
`include "mem_system_macros.svh"

module cache_ctrl
   import addr_pkg::*, cache_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic [`ADDR_W-1:0] addr,
   input  word_t data_in,
   input  logic rd,
   input  logic wr,
   output word_t data_out,
   output logic done,
   output logic stall,
   output logic cache_hit,
   output logic err,
   output logic w0_en, w0_write, w0_set_dirty, w0_fill,
   output index_t w0_index,
   output offset_t w0_offset,
   output tag_t w0_tag_in,
   output word_t w0_data_in,
   input  logic w0_hit, w0_dirty, w0_valid,
   input  tag_t w0_tag_out,
   input  word_t w0_data_out,
   output logic w1_en, w1_write, w1_set_dirty, w1_fill,
   output index_t w1_index,
   output offset_t w1_offset,
   output tag_t w1_tag_in,
   output word_t w1_data_in,
   input  logic w1_hit, w1_dirty, w1_valid,
   input  tag_t w1_tag_out,
   input  word_t w1_data_out,
   output logic [`ADDR_W-1:0] mem_addr,
   output word_t mem_data_in,
   output logic mem_rd,
   output logic mem_wr,
   input  word_t mem_data_out,
   input  logic mem_stall,
   input  logic [`NUM_BANKS-1:0] mem_busy
);

   localparam int CNT_W = $clog2(`LINE_WORDS);
   localparam logic [CNT_W-1:0] LAST = CNT_W'(`LINE_WORDS - 1);

   ctrl_state_t             state;
   tag_t                    req_tag;
   index_t                  req_index;
   offset_t                 req_offset;
   word_t                   req_data;
   logic                    req_wr;
   logic [`NUM_SETS-1:0]    lru;          // Most recently used way per set
   logic                    victim, pick, sel_way, any_hit, mem_acc, rd_back, err_q;
   logic [CNT_W-1:0]        issue_cnt, recv_cnt;
   logic [`MEM_RD_LAT-1:0]  rd_pend;
   logic [1:0]              way_en, way_write, way_fill, victim_oh;
   offset_t                 way_offset;

   assign any_hit   = w0_hit | w1_hit;
   assign victim_oh = victim ? 2'b10 : 2'b01;
   assign sel_way   = (state == st_lookup) ? w1_hit : victim;

   always_comb begin
      if (!w0_valid)      pick = 1'b0;
      else if (!w1_valid) pick = 1'b1;
      else                pick = ~lru[req_index];
   end

   // Bank of each word is its line position
   assign mem_addr    = {(state == st_writeback) ? (victim ? w1_tag_out : w0_tag_out) : req_tag,
                         req_index, issue_cnt, 1'b0};
   assign mem_data_in = victim ? w1_data_out : w0_data_out;
   assign mem_wr      = (state == st_writeback);
   assign mem_rd      = (state == st_fill);
   assign mem_acc     = (mem_rd | mem_wr) & ~mem_stall;
   assign rd_back     = rd_pend[`MEM_RD_LAT-1];   // Read word arrives this cycle

   always_comb begin
      way_en     = 2'b00;
      way_write  = 2'b00;
      way_fill   = 2'b00;
      way_offset = req_offset;
      case (state)
         st_lookup: begin
            way_en    = 2'b11;
            way_write = {w1_hit, w0_hit} & {2{req_wr}};
         end
         st_writeback: begin
            way_en     = victim_oh;
            way_offset = {issue_cnt, 1'b0};
         end
         st_fill, st_fill_wait: begin
            way_en     = victim_oh;
            way_fill   = victim_oh & {2{rd_back}};
            way_offset = {recv_cnt, 1'b0};
         end
         st_finish: begin
            way_en    = victim_oh;
            way_write = victim_oh & {2{req_wr}};
         end
         default: ;
      endcase
   end

   assign w0_en = way_en[0];
   assign w0_write = way_write[0];
   assign w0_set_dirty = way_write[0];
   assign w0_fill = way_fill[0];
   assign w0_index = req_index;
   assign w0_offset = way_offset;
   assign w0_tag_in = req_tag;
   assign w0_data_in = (state == st_finish || state == st_lookup) ? req_data : mem_data_out;
   assign w1_en = way_en[1];
   assign w1_write = way_write[1];
   assign w1_set_dirty = way_write[1];
   assign w1_fill = way_fill[1];
   assign w1_index = req_index;
   assign w1_offset = way_offset;
   assign w1_tag_in = req_tag;
   assign w1_data_in = w0_data_in;

   assign done      = (state == st_lookup && any_hit) || state == st_finish;
   assign cache_hit = (state == st_lookup) & any_hit;
   assign stall     = (state != st_idle);
   assign err       = err_q;
   assign data_out  = sel_way ? w1_data_out : w0_data_out;

   always_ff @(posedge clk) begin
      if (state == st_idle && (rd || wr)) begin
         req_tag    <= addr[`ADDR_W-1 -: `TAG_W];
         req_index  <= addr[`OFFSET_W +: `INDEX_W];
         req_offset <= addr[`OFFSET_W-1:0];
         req_data   <= data_in;
         req_wr     <= wr;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= st_idle;
         victim    <= 1'b0;
         issue_cnt <= '0;
         recv_cnt  <= '0;
         rd_pend   <= '0;
         lru       <= '0;
         err_q     <= 1'b0;
      end else begin
         err_q   <= 1'b0;
         rd_pend <= {rd_pend[`MEM_RD_LAT-2:0], mem_rd & ~mem_stall};
         if (mem_acc) issue_cnt <= issue_cnt + 1'b1;   // Wraps to 0 after a line
         if (rd_back) recv_cnt <= recv_cnt + 1'b1;
         if (done) lru[req_index] <= sel_way;
         case (state)
            st_idle:
               if (rd || wr) begin
                  if ((rd && wr) || addr[0]) err_q <= 1'b1;
                  else state <= st_lookup;
               end
            st_lookup:
               if (!any_hit) begin
                  victim <= pick;
                  state  <= (pick ? w1_dirty : w0_dirty) ? st_writeback : st_fill;
               end else begin
                  state <= st_idle;
               end
            st_writeback: if (mem_acc && issue_cnt == LAST) state <= st_fill;
            st_fill:      if (mem_acc && issue_cnt == LAST) state <= st_fill_wait;
            st_fill_wait: if (rd_back && recv_cnt == LAST) state <= st_finish;
            default:      state <= st_idle;
         endcase
      end
   end

endmodule

// File: mem_system.sv
/*
 * Data memory subsystem top: controller, two cache ways, banked memory
 */
`timescale 1ns/1ps
`include "mem_system_macros.svh"

module mem_system
   import addr_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic [`ADDR_W-1:0] addr,
   input  word_t              data_in,
   input  logic               rd,
   input  logic               wr,
   output word_t              data_out,
   output logic               done,
   output logic               stall,
   output logic               cache_hit,
   output logic               err
);

   logic    w0_en, w0_write, w0_set_dirty, w0_fill, w0_hit, w0_dirty, w0_valid;
   logic    w1_en, w1_write, w1_set_dirty, w1_fill, w1_hit, w1_dirty, w1_valid;
   index_t  w0_index, w1_index;
   offset_t w0_offset, w1_offset;
   tag_t    w0_tag_in, w0_tag_out, w1_tag_in, w1_tag_out;
   word_t   w0_data_in, w0_data_out, w1_data_in, w1_data_out;

   logic [`ADDR_W-1:0]    mem_addr;
   word_t                 mem_data_in, mem_data_out;
   logic                  mem_rd, mem_wr, mem_stall;
   logic [`NUM_BANKS-1:0] mem_busy;

   cache_ctrl i_cache_ctrl (.*);

   cache_way i_way0 (
      .clk (clk), .rst_n (rst_n), .en (w0_en), .index (w0_index), .offset (w0_offset),
      .tag_in (w0_tag_in), .data_in (w0_data_in), .write (w0_write),
      .set_dirty (w0_set_dirty), .fill (w0_fill), .data_out (w0_data_out),
      .tag_out (w0_tag_out), .hit (w0_hit), .dirty (w0_dirty), .valid (w0_valid)
   );

   cache_way i_way1 (
      .clk (clk), .rst_n (rst_n), .en (w1_en), .index (w1_index), .offset (w1_offset),
      .tag_in (w1_tag_in), .data_in (w1_data_in), .write (w1_write),
      .set_dirty (w1_set_dirty), .fill (w1_fill), .data_out (w1_data_out),
      .tag_out (w1_tag_out), .hit (w1_hit), .dirty (w1_dirty), .valid (w1_valid)
   );

   four_bank_mem i_mem (
      .clk      (clk),
      .rst_n    (rst_n),
      .addr     (mem_addr),
      .data_in  (mem_data_in),
      .rd       (mem_rd),
      .wr       (mem_wr),
      .data_out (mem_data_out),
      .stall    (mem_stall),
      .busy     (mem_busy)
   );

endmodule

// File: tb_mem_system.sv
/*
 * Testbench for the data memory subsystem
 * Reference model of words and tag state, concurrent checks, random traffic, watchdog
 */
`timescale 1ns/1ps
`include "mem_system_macros.svh"

module tb_mem_system
   import addr_pkg::*;
();

   localparam int PERIOD    = 40;
   localparam int REQ_LIMIT = 60;   // Cycles allowed for one request
   localparam int MAX_REQ   = 130;
   localparam int MISS_CYC  = 30;   // Dirty miss, rounded up

   logic               clk;
   logic               rst_n;
   logic [`ADDR_W-1:0] addr;
   word_t              data_in;
   word_t              data_out;
   logic               rd, wr, done, stall, cache_hit, err;

   // Expectations, only changed on the falling edge
   logic  req_open = 1'b0;
   logic  first_cycle = 1'b0;
   logic  stall_window = 1'b0;
   logic  exp_err = 1'b0;
   logic  exp_hit = 1'b0;
   logic  chk_rd = 1'b0;
   word_t exp_data = '0;

   word_t             mem_model [int];   // Word address to contents
   logic [`TAG_W-1:0] tag_m [`NUM_SETS][2];
   logic              vld_m [`NUM_SETS][2];
   logic              mru_m [`NUM_SETS];

   int seed = 92983;
   int fail_cnt = 0;
   int fails_before = 0;
   int n_tests = 0;
   int n_req = 0;

   mem_system i_mem_system (.*);

   initial begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   initial begin
      #(PERIOD * (MAX_REQ * MISS_CYC + 100));
      $display("Watchdog expired before the tests completed");
      $display("Regression failed");
      $finish;
   end

   quiet_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
      !req_open |-> !done && !stall && !cache_hit && !err)
      else begin
         $display("Handshake output active with no request open at %0t", $time);
         fail_cnt = fail_cnt + 1;
      end

   stall_held: assert property (@(posedge clk) disable iff (!rst_n)
      stall_window |-> stall)
      else begin
         $display("Stall dropped between acceptance and done at %0t", $time);
         fail_cnt = fail_cnt + 1;
      end

   hit_in_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      first_cycle && exp_hit |-> done)
      else begin
         $display("Done missing one cycle after an accepted hit at %0t", $time);
         fail_cnt = fail_cnt + 1;
      end

   hit_flag: assert property (@(posedge clk) disable iff (!rst_n)
      done |-> cache_hit == exp_hit)
      else begin
         $display("MISMATCH at %0t: cache_hit %b, expected %b", $time, cache_hit, exp_hit);
         fail_cnt = fail_cnt + 1;
      end

   read_data: assert property (@(posedge clk) disable iff (!rst_n)
      done && chk_rd |-> data_out == exp_data)
      else begin
         $display("MISMATCH at %0t: read data %h, expected %h", $time, data_out, exp_data);
         fail_cnt = fail_cnt + 1;
      end

   err_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      first_cycle && exp_err |-> err)
      else begin
         $display("No err pulse one cycle after a bad request at %0t", $time);
         fail_cnt = fail_cnt + 1;
      end

   err_rules: assert property (@(posedge clk) disable iff (!rst_n)
      req_open |-> (exp_err ? !done : !err))
      else begin
         $display("Bad request gave done, or a good one gave err, at %0t", $time);
         fail_cnt = fail_cnt + 1;
      end

   function automatic word_t stored_word(input logic [`ADDR_W-2:0] wa);
      return mem_model.exists(int'(wa)) ? mem_model[int'(wa)] : '0;
   endfunction

   function automatic logic [`ADDR_W-1:0] make_addr(input logic [`TAG_W-1:0] t,
                                                    input logic [`INDEX_W-1:0] i,
                                                    input logic [1:0] w);
      return {t, i, w, 1'b0};
   endfunction

   // Hit or miss per set, victim is an invalid way first, else the one not most recent
   task automatic lookup_tags(input logic [`ADDR_W-1:0] a, output logic hit);
      int                idx;
      logic [`TAG_W-1:0] t;
      logic              way;
      idx = int'(a[10:3]);
      t   = a[15:11];
      hit = 1'b1;
      if (vld_m[idx][0] && tag_m[idx][0] == t) begin
         way = 1'b0;
      end else if (vld_m[idx][1] && tag_m[idx][1] == t) begin
         way = 1'b1;
      end else begin
         hit = 1'b0;
         if (!vld_m[idx][0]) way = 1'b0;
         else if (!vld_m[idx][1]) way = 1'b1;
         else way = ~mru_m[idx];
         vld_m[idx][way] = 1'b1;
         tag_m[idx][way] = t;
      end
      mru_m[idx] = way;
   endtask

   // Called on a falling edge with the DUT idle
   task automatic send_request(input logic r, input logic w,
                               input logic [`ADDR_W-1:0] a, input word_t d);
      int   wait_cyc;
      logic bad;
      logic hit;
      bad      = (r && w) || a[0];
      exp_err  = bad;
      chk_rd   = r && !w;
      exp_data = stored_word(a[15:1]);
      exp_hit  = 1'b0;
      if (!bad) begin
         lookup_tags(a, hit);
         exp_hit = hit;
         if (w) mem_model[int'(a[15:1])] = d;
      end
      rd       = r;
      wr       = w;
      addr     = a;
      data_in  = d;
      req_open = 1'b1;
      @(negedge clk);
      rd           = 1'b0;
      wr           = 1'b0;
      first_cycle  = 1'b1;
      stall_window = !bad;
      wait_cyc     = 0;
      while (!done && !err && wait_cyc < REQ_LIMIT) begin
         @(negedge clk);
         first_cycle = 1'b0;
         wait_cyc++;
      end
      if (wait_cyc >= REQ_LIMIT) begin
         $display("Request to %h got neither done nor err in %0d cycles", a, REQ_LIMIT);
         $display("Regression failed");
         $finish;
      end
      @(negedge clk);   // Done or err cycle is sampled at this rising edge
      first_cycle  = 1'b0;
      stall_window = 1'b0;
      req_open     = 1'b0;
      exp_err      = 1'b0;
      chk_rd       = 1'b0;
      exp_hit      = 1'b0;
      n_req++;
   endtask

   task automatic read_word(input logic [`ADDR_W-1:0] a);
      send_request(1'b1, 1'b0, a, '0);
   endtask

   task automatic write_word(input logic [`ADDR_W-1:0] a, input word_t d);
      send_request(1'b0, 1'b1, a, d);
   endtask

   task automatic report_test(input string name);
      n_tests++;
      $display("Test %0d %s: %0d failures", n_tests, name, fail_cnt - fails_before);
      fails_before = fail_cnt;
   endtask

   initial begin
      logic [`ADDR_W-1:0] a;
      logic [31:0]        r;
      rst_n   = 1'b0;
      rd      = 1'b0;
      wr      = 1'b0;
      addr    = '0;
      data_in = '0;
      for (int s = 0; s < `NUM_SETS; s++) begin
         vld_m[s][0] = 1'b0;
         vld_m[s][1] = 1'b0;
         mru_m[s]    = 1'b0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      repeat (3) @(negedge clk);

      read_word(make_addr(5'd31, 8'd255, 2'd3));
      read_word(make_addr(5'd2, 8'd70, 2'd1));
      read_word(16'h0000);
      report_test("reset state and unwritten reads");

      for (int n = 0; n < 80; n++) begin
         r = $random(seed);
         a = {3'b000, r[1:0], 6'b000000, r[3:2], r[5:4], 1'b0};   // Few tags and sets
         if (r[6]) write_word(a, r[31:16]);
         else read_word(a);
      end
      report_test("random reads and writes");

      read_word(make_addr(5'd1, 8'd100, 2'd0));
      read_word(make_addr(5'd2, 8'd100, 2'd1));
      read_word(make_addr(5'd1, 8'd100, 2'd2));
      read_word(make_addr(5'd3, 8'd100, 2'd0));   // Evicts tag 2
      read_word(make_addr(5'd1, 8'd100, 2'd3));
      read_word(make_addr(5'd2, 8'd100, 2'd0));
      report_test("hit timing and LRU victim");

      write_word(make_addr(5'd4, 8'd200, 2'd1), 16'ha11a);
      write_word(make_addr(5'd5, 8'd200, 2'd2), 16'hb22b);
      write_word(make_addr(5'd6, 8'd200, 2'd3), 16'hc33c);
      read_word(make_addr(5'd4, 8'd200, 2'd1));
      read_word(make_addr(5'd5, 8'd200, 2'd2));
      report_test("dirty eviction");

      for (int i = 0; i < 4; i++) begin
         write_word(make_addr(5'd9, 8'(60 + i), 2'(i)), word_t'(16'h5000 + i));
      end
      for (int i = 0; i < 4; i++) begin
         read_word(make_addr(5'd9, 8'(60 + i), 2'(i)));
      end
      report_test("stall through back-to-back misses");

      a = make_addr(5'd1, 8'd10, 2'd2);
      write_word(a, 16'h1357);
      send_request(1'b0, 1'b1, a | 16'h0001, 16'hdead);
      send_request(1'b1, 1'b0, a | 16'h0001, '0);
      send_request(1'b1, 1'b1, a, 16'hbeef);
      read_word(a);
      report_test("request errors");

      repeat (3) @(negedge clk);
      $display("Tests %0d, requests %0d, failed checks %0d", n_tests, n_req, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: mem_system.f
+incdir+.
addr_pkg.sv
cache_pkg.sv
way_ram.sv
cache_way.sv
four_bank_mem.sv
cache_ctrl.sv
mem_system.sv
tb_mem_system.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the mem_system regression
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mem_system -f mem_system.f
./obj_dir/Vtb_mem_system > sim.log
cat sim.log

if grep -q "Regression failed" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi
echo "Simulation finished without failure"
